// ==== all.f ====
hw/wb2axil_pkg.sv
hw/wb2axil_track_if.sv
hw/wb2axil_req_issue.sv
hw/wb2axil_txn_tracker.sv
hw/wb2axil_resp_return.sv
hw/wb2axil_bridge.sv
sim/axil_slave_model.sv
sim/tb_wb2axil.sv

// ==== hw/wb2axil_bridge.sv ====
////////////////////////////////////////////////////////////
// Pipelined WB master to AXI-lite slave bridge, 32-bit words
// BREADY and RREADY are tied high, PROT is fixed to data access
// Stall stays high for the reset hold, wait for it to fall
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module wb2axil_bridge
	import wb2axil_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_reset,
	// Wishbone pipelined slave side
	input  logic      i_wb_cyc,
	input  logic      i_wb_stb,
	input  logic      i_wb_we,
	input  wb_addr_t  i_wb_addr,
	input  data_t     i_wb_data,
	input  sel_t      i_wb_sel,
	output logic      o_wb_stall,
	output logic      o_wb_ack,
	output data_t     o_wb_data,
	output logic      o_wb_err,
	// AXI write address
	output logic      o_axi_awvalid,
	input  logic      i_axi_awready,
	output axi_addr_t o_axi_awaddr,
	output logic [2:0] o_axi_awprot,
	// AXI write data
	output logic      o_axi_wvalid,
	input  logic      i_axi_wready,
	output data_t     o_axi_wdata,
	output sel_t      o_axi_wstrb,
	// AXI write response
	input  logic      i_axi_bvalid,
	output logic      o_axi_bready,
	input  resp_t     i_axi_bresp,
	// AXI read address
	output logic      o_axi_arvalid,
	input  logic      i_axi_arready,
	output axi_addr_t o_axi_araddr,
	output logic [2:0] o_axi_arprot,
	// AXI read data
	input  logic      i_axi_rvalid,
	output logic      o_axi_rready,
	input  data_t     i_axi_rdata,
	input  resp_t     i_axi_rresp
);

	// Fixed AXI outputs
	assign o_axi_awprot = AXI_PROT_DATA;
	assign o_axi_arprot = AXI_PROT_DATA;
	// Responses are never back-pressured
	assign o_axi_bready = 1'b1;
	assign o_axi_rready = 1'b1;

	wb2axil_track_if trk ();

	//////////////////////////////////////////////////////////////
	// Request issue
	//////////////////////////////////////////////////////////////

	wb2axil_req_issue u_issue (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_wb_stb      (i_wb_stb),
		.i_wb_we       (i_wb_we),
		.i_wb_addr     (i_wb_addr),
		.i_wb_data     (i_wb_data),
		.i_wb_sel      (i_wb_sel),
		.o_wb_stall    (o_wb_stall),
		.o_axi_awvalid (o_axi_awvalid),
		.i_axi_awready (i_axi_awready),
		.o_axi_awaddr  (o_axi_awaddr),
		.o_axi_wvalid  (o_axi_wvalid),
		.i_axi_wready  (i_axi_wready),
		.o_axi_wdata   (o_axi_wdata),
		.o_axi_wstrb   (o_axi_wstrb),
		.o_axi_arvalid (o_axi_arvalid),
		.i_axi_arready (i_axi_arready),
		.o_axi_araddr  (o_axi_araddr),
		.trk           (trk.issue)
	);

	//////////////////////////////////////////////////////////////
	// Transaction tracking
	//////////////////////////////////////////////////////////////

	// Only unit that sees the cycle line
	wb2axil_txn_tracker u_tracker (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_wb_cyc (i_wb_cyc),
		.trk      (trk.tracker)
	);

	//////////////////////////////////////////////////////////////
	// Response return
	//////////////////////////////////////////////////////////////

	wb2axil_resp_return u_return (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_axi_bvalid (i_axi_bvalid),
		.i_axi_bresp  (i_axi_bresp),
		.i_axi_rvalid (i_axi_rvalid),
		.i_axi_rdata  (i_axi_rdata),
		.i_axi_rresp  (i_axi_rresp),
		.o_wb_ack     (o_wb_ack),
		.o_wb_err     (o_wb_err),
		.o_wb_data    (o_wb_data),
		.trk          (trk.ret)
	);

endmodule

// ==== hw/wb2axil_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths, limits and types of the WB to AXI-lite bridge
// Only the single 32-bit word setup is supported, no bursts or IDs
// Tracker depth is 2**LG_FIFO, and at most MAX_INFLIGHT may be in flight
////////////////////////////////////////////////////////////
package wb2axil_pkg;

	//////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////

	// Data path is one 32-bit word
	localparam int DATA_W = 32;
	// One strobe per byte lane
	localparam int SEL_W = DATA_W / 8;
	// AXI side addresses bytes
	localparam int AXI_ADDR_W = 28;
	// Wishbone side addresses words, so two bits fewer
	localparam int WB_ADDR_W = AXI_ADDR_W - 2;

	//////////////////////////////////////////////////////////////
	// Limits
	//////////////////////////////////////////////////////////////

	// Log2 of tracking depth
	localparam int LG_FIFO = 5;
	// Stall once this many requests are unanswered
	localparam int MAX_INFLIGHT = 30;
	// Cycles of hold after reset, counted down to zero
	localparam int RESET_HOLD = 15;
	// Unprivileged, non-secure, data access
	localparam logic [2:0] AXI_PROT_DATA = 3'b010;

	//////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [SEL_W-1:0] sel_t;
	typedef logic [WB_ADDR_W-1:0] wb_addr_t;
	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	// Bit 1 set means SLVERR or DECERR
	typedef logic [1:0] resp_t;
	typedef logic [LG_FIFO-1:0] count_t;

	// Tracker FSM
	typedef enum logic [1:0] {
		ST_HOLD,
		ST_RUN,
		ST_DRAIN
	} track_state_t;

endpackage

// ==== hw/wb2axil_req_issue.sv ====
////////////////////////////////////////////////////////////
// Request side of the bridge: WB stall and the AW, W and AR channels
// Stall is combinational from the ready inputs
// Only one direction is in flight at a time
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module wb2axil_req_issue
	import wb2axil_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_reset,
	// Wishbone request
	input  logic      i_wb_stb,
	input  logic      i_wb_we,
	input  wb_addr_t  i_wb_addr,
	input  data_t     i_wb_data,
	input  sel_t      i_wb_sel,
	output logic      o_wb_stall,
	// AXI write address
	output logic      o_axi_awvalid,
	input  logic      i_axi_awready,
	output axi_addr_t o_axi_awaddr,
	// AXI write data
	output logic      o_axi_wvalid,
	input  logic      i_axi_wready,
	output data_t     o_axi_wdata,
	output sel_t      o_axi_wstrb,
	// AXI read address
	output logic      o_axi_arvalid,
	input  logic      i_axi_arready,
	output axi_addr_t o_axi_araddr,
	// Tracker link
	wb2axil_track_if.issue trk
);

	// Request channel still waiting on its ready
	logic aw_busy;
	logic w_busy;
	logic ar_busy;
	// Direction switch while requests are unanswered
	logic dir_change;
	logic take;
	// Byte address shared by AW and AR
	axi_addr_t req_addr;

	//////////////////////////////////////////////////////////////
	// Stall and accept
	//////////////////////////////////////////////////////////////

	assign aw_busy = o_axi_awvalid && !i_axi_awready;
	assign w_busy = o_axi_wvalid && !i_axi_wready;
	assign ar_busy = o_axi_arvalid && !i_axi_arready;

	// Old direction must fully answer before the new one goes out
	assign dir_change = trk.pending && (i_wb_we != trk.last_we);

	assign o_wb_stall = trk.blocked || dir_change || aw_busy || w_busy || ar_busy;

	assign take = i_wb_stb && !o_wb_stall;
	assign trk.accept = take;
	assign trk.accept_we = i_wb_we;

	//////////////////////////////////////////////////////////////
	// Channel valids
	//////////////////////////////////////////////////////////////

	// Set one cycle after accept, held until the matching ready
	// AW and W retire on their own
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			o_axi_awvalid <= 1'b0;
			o_axi_wvalid <= 1'b0;
			o_axi_arvalid <= 1'b0;
		end
		else
		begin
			o_axi_awvalid <= (take && i_wb_we) || aw_busy;
			o_axi_wvalid <= (take && i_wb_we) || w_busy;
			o_axi_arvalid <= (take && !i_wb_we) || ar_busy;
		end

	//////////////////////////////////////////////////////////////
	// Payload
	//////////////////////////////////////////////////////////////

	// Free to reload whenever stall is low, since no channel waits then
	always_ff @(posedge i_clk)
		if (!o_wb_stall)
		begin
			// Word address to byte address
			req_addr <= {i_wb_addr, 2'b00};
			o_axi_wdata <= i_wb_data;
			o_axi_wstrb <= i_wb_sel;
		end

	assign o_axi_awaddr = req_addr;
	assign o_axi_araddr = req_addr;

	//////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////

	// Direction stall keeps reads and writes apart on the AXI side
	a_one_direction: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_axi_arvalid && (o_axi_awvalid || o_axi_wvalid)));

	// Nothing left over on AXI once reset has been seen
	a_reset_idle: assert property (@(posedge i_clk)
		i_reset |=> !o_axi_awvalid && !o_axi_wvalid && !o_axi_arvalid);

endmodule

// ==== hw/wb2axil_resp_return.sv ====
////////////////////////////////////////////////////////////
// Turns AXI B and R beats into WB ack, err and read data
// Ack and err follow the beat by exactly one cycle
// Read data is sampled every cycle and only valid with ack
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module wb2axil_resp_return
	import wb2axil_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_reset,
	// AXI responses, always accepted
	input  logic  i_axi_bvalid,
	input  resp_t i_axi_bresp,
	input  logic  i_axi_rvalid,
	input  data_t i_axi_rdata,
	input  resp_t i_axi_rresp,
	// Wishbone answer
	output logic  o_wb_ack,
	output logic  o_wb_err,
	output data_t o_wb_data,
	// Tracker link
	wb2axil_track_if.ret trk
);

	logic beat_ok;
	logic beat_bad;

	// Only bit 1 matters, OKAY and EXOKAY both count as good
	assign beat_ok = (i_axi_bvalid && !i_axi_bresp[1]) || (i_axi_rvalid && !i_axi_rresp[1]);
	assign beat_bad = (i_axi_bvalid && i_axi_bresp[1]) || (i_axi_rvalid && i_axi_rresp[1]);

	assign trk.resp_seen = i_axi_bvalid || i_axi_rvalid;
	assign trk.resp_err = beat_bad;

	// Flush swallows answers to a dropped cycle or during drain
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			o_wb_ack <= 1'b0;
			o_wb_err <= 1'b0;
		end
		else
		begin
			o_wb_ack <= beat_ok && !trk.flush;
			o_wb_err <= beat_bad && !trk.flush;
		end

	always_ff @(posedge i_clk)
		o_wb_data <= i_axi_rdata;

	assign trk.ack_out = o_wb_ack;

	// B and R never overlap while the issue unit keeps one direction
	a_ack_xor_err: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_wb_ack && o_wb_err));

endmodule

// ==== hw/wb2axil_track_if.sv ====
////////////////////////////////////////////////////////////
// Status and event lines shared by issue, tracker and return units
// All signals are single bits in the i_clk domain, no clock inside
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface wb2axil_track_if;

	// From the issue unit
	// One-cycle pulse when a WB request is taken
	logic accept;
	// Direction of that request, high for a write
	logic accept_we;

	// From the return unit
	// A B or R beat was seen this cycle
	logic resp_seen;
	// That beat carried SLVERR or DECERR
	logic resp_err;
	// Registered WB ack, as driven on the bus
	logic ack_out;

	// From the tracker
	// Hold, drain or full
	logic blocked;
	// At least one request still unanswered
	logic pending;
	// Direction of the unanswered requests
	logic last_we;
	// Cycle dropped or draining, so answers are thrown away
	logic flush;

	modport issue (
		output accept,
		output accept_we,
		input  blocked,
		input  pending,
		input  last_we
	);

	modport tracker (
		input  accept,
		input  accept_we,
		input  resp_seen,
		input  resp_err,
		input  ack_out,
		output blocked,
		output pending,
		output last_we,
		output flush
	);

	modport ret (
		output resp_seen,
		output resp_err,
		output ack_out,
		input  flush
	);

endinterface

// ==== hw/wb2axil_txn_tracker.sv ====
////////////////////////////////////////////////////////////
// Tracks requests between accept and answer, owns hold and drain FSM
// Hold ends at most RESET_HOLD+1 cycles after reset is released
// Drain waits for every AXI response still due, counted from accept
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module wb2axil_txn_tracker
	import wb2axil_pkg::*;
(
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_wb_cyc,
	wb2axil_track_if.tracker trk
);

	track_state_t state;
	// Countdown of the hold after reset
	count_t hold_cnt;
	// Requests accepted and not yet acked on WB
	count_t out_cnt;
	// Requests accepted and not yet answered on AXI
	count_t drain_cnt;
	logic pending_q;
	logic full_q;
	logic last_we_q;

	//////////////////////////////////////////////////////////////
	// Hold, run and drain FSM
	//////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			state <= ST_HOLD;
			hold_cnt <= count_t'(RESET_HOLD);
		end
		else
		begin
			case (state)
			ST_HOLD:
				if (hold_cnt == '0)
					state <= ST_RUN;
				else
					hold_cnt <= hold_cnt - 1'b1;
			ST_RUN:
				// AXI error, or master gave up with answers still due
				if (trk.resp_err || (!i_wb_cyc && pending_q))
					state <= ST_DRAIN;
			ST_DRAIN:
				if (drain_cnt == '0)
					state <= ST_RUN;
			default:
				state <= ST_HOLD;
			endcase
		end

	//////////////////////////////////////////////////////////////
	// Outstanding WB requests
	//////////////////////////////////////////////////////////////

	// Cleared whenever answers are being thrown away
	always_ff @(posedge i_clk)
		if (i_reset || (state == ST_HOLD) || trk.flush)
		begin
			out_cnt <= '0;
			pending_q <= 1'b0;
			full_q <= 1'b0;
		end
		else
		begin
			case ({trk.accept, trk.ack_out})
			2'b10:
			begin
				out_cnt <= out_cnt + 1'b1;
				pending_q <= 1'b1;
				// Full once this accept brings the count to the limit
				full_q <= (out_cnt >= count_t'(MAX_INFLIGHT - 1));
			end
			2'b01:
			begin
				out_cnt <= out_cnt - 1'b1;
				pending_q <= (out_cnt >= count_t'(2));
				full_q <= 1'b0;
			end
			default:
				;
			endcase
		end

	// Direction of whatever is in flight
	always_ff @(posedge i_clk)
		if (i_reset)
			last_we_q <= 1'b0;
		else if (trk.accept)
			last_we_q <= trk.accept_we;

	//////////////////////////////////////////////////////////////
	// Responses still due from AXI
	//////////////////////////////////////////////////////////////

	// Not cleared on flush, the slave still owes these beats
	always_ff @(posedge i_clk)
		if (i_reset)
			drain_cnt <= '0;
		else
		begin
			case ({trk.accept, trk.resp_seen})
			2'b10:
				drain_cnt <= drain_cnt + 1'b1;
			2'b01:
				drain_cnt <= drain_cnt - 1'b1;
			default:
				;
			endcase
		end

	//////////////////////////////////////////////////////////////
	// Status out
	//////////////////////////////////////////////////////////////

	assign trk.blocked = (state != ST_RUN) || full_q;
	assign trk.pending = pending_q;
	assign trk.last_we = last_we_q;
	assign trk.flush = !i_wb_cyc || (state == ST_DRAIN);

	// Stall on full in the issue unit has to hold the count down
	a_count_limit: assert property (@(posedge i_clk) disable iff (i_reset)
		out_cnt <= count_t'(MAX_INFLIGHT));

	// Registered flag has to track the counter across all branches
	a_pending_match: assert property (@(posedge i_clk) disable iff (i_reset)
		pending_q == (out_cnt != '0));

endmodule

// ==== sim/axil_slave_model.sv ====
////////////////////////////////////////////////////////////
// AXI-lite memory responder for the bridge testbench, 64 words
// Ready outputs stall at random, expects BREADY and RREADY high
// One byte address answers SLVERR and is never written
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module axil_slave_model
	import wb2axil_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_reset,
	input  axi_addr_t i_err_addr,
	// Write side
	input  logic      i_awvalid,
	output logic      o_awready,
	input  axi_addr_t i_awaddr,
	input  logic      i_wvalid,
	output logic      o_wready,
	input  data_t     i_wdata,
	input  sel_t      i_wstrb,
	output logic      o_bvalid,
	output resp_t     o_bresp,
	// Read side
	input  logic      i_arvalid,
	output logic      o_arready,
	input  axi_addr_t i_araddr,
	output logic      o_rvalid,
	output data_t     o_rdata,
	output resp_t     o_rresp
);

	integer seed;
	// One random bit per ready line, new every cycle
	logic [2:0] rnd;
	logic have_aw;
	logic have_w;
	axi_addr_t aw_q;
	data_t w_q;
	sel_t strb_q;
	data_t mem [0:63];

	initial
	begin
		int i;
		seed = 80446;
		// Quiet bus until the first reset edge
		rnd = '0;
		have_aw = 1'b0;
		have_w = 1'b0;
		o_bvalid = 1'b0;
		o_bresp = 2'b00;
		o_rvalid = 1'b0;
		o_rresp = 2'b00;
		o_rdata = '0;
		// Fill depends on the whole word index
		for (i = 0; i < 64; i++)
			mem[i] = 32'hc0de_0000 | 32'(i * 257);
	end

	always @(posedge i_clk)
		rnd <= 3'($random(seed));

	// AW and W are each held once taken, until both are in
	assign o_awready = !have_aw && rnd[0];
	assign o_wready = !have_w && rnd[1];
	assign o_arready = rnd[2];

	//////////////////////////////////////////////////////////////
	// Write path
	//////////////////////////////////////////////////////////////

	always @(posedge i_clk)
		if (i_reset)
		begin
			have_aw <= 1'b0;
			have_w <= 1'b0;
			o_bvalid <= 1'b0;
			o_bresp <= 2'b00;
		end
		else
		begin
			o_bvalid <= 1'b0;
			if (i_awvalid && o_awready)
			begin
				have_aw <= 1'b1;
				aw_q <= i_awaddr;
			end
			if (i_wvalid && o_wready)
			begin
				have_w <= 1'b1;
				w_q <= i_wdata;
				strb_q <= i_wstrb;
			end
			// Both halves present, commit and answer next cycle
			if (have_aw && have_w)
			begin
				have_aw <= 1'b0;
				have_w <= 1'b0;
				o_bvalid <= 1'b1;
				o_bresp <= (aw_q == i_err_addr) ? 2'b10 : 2'b00;
				for (int b = 0; b < SEL_W; b++)
					if (strb_q[b] && (aw_q != i_err_addr))
						mem[aw_q[7:2]][8*b +: 8] <= w_q[8*b +: 8];
			end
		end

	//////////////////////////////////////////////////////////////
	// Read path
	//////////////////////////////////////////////////////////////

	// One R beat per AR handshake, one cycle later
	always @(posedge i_clk)
		if (i_reset)
		begin
			o_rvalid <= 1'b0;
			o_rresp <= 2'b00;
		end
		else
		begin
			o_rvalid <= i_arvalid && o_arready;
			o_rdata <= mem[i_araddr[7:2]];
			o_rresp <= (i_araddr == i_err_addr) ? 2'b10 : 2'b00;
		end

endmodule

// ==== sim/tb_wb2axil.sv ====
////////////////////////////////////////////////////////////
// Self-checking testbench for the WB to AXI-lite bridge
// Reads only target words written before, word 63 answers SLVERR
// Runs are cut off by a cycle counter
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_wb2axil
	import wb2axil_pkg::*;
();

	// About four times the longest sequence
	localparam int CYCLE_LIMIT = 3000;
	localparam wb_addr_t ERR_WORD = wb_addr_t'(63);
	// Unprivileged, non-secure, data access in AXI PROT encoding
	localparam logic [2:0] EXP_PROT = 3'b010;

	// One expected answer per accepted request
	typedef struct packed {
		logic  we;
		logic  err;
		data_t data;
	} exp_t;

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_addr_t wb_addr;
	data_t wb_wdata;
	sel_t wb_sel;
	logic wb_stall;
	logic wb_ack;
	logic wb_err;
	data_t wb_rdata;
	logic axi_awvalid;
	logic axi_awready;
	axi_addr_t axi_awaddr;
	logic [2:0] axi_awprot;
	logic axi_wvalid;
	logic axi_wready;
	data_t axi_wdata;
	sel_t axi_wstrb;
	logic axi_bvalid;
	logic axi_bready;
	resp_t axi_bresp;
	logic axi_arvalid;
	logic axi_arready;
	axi_addr_t axi_araddr;
	logic [2:0] axi_arprot;
	logic axi_rvalid;
	logic axi_rready;
	data_t axi_rdata;
	resp_t axi_rresp;

	// Scoreboard state
	exp_t exp_q [$];
	data_t model [0:63];
	logic cyc_prev;
	logic tb_pending;
	logic last_we;
	int errors = 0;
	int cycles = 0;
	string test_name;

	wb2axil_bridge uut (
		.i_clk (clk), .i_reset (reset),
		.i_wb_cyc (wb_cyc), .i_wb_stb (wb_stb), .i_wb_we (wb_we),
		.i_wb_addr (wb_addr), .i_wb_data (wb_wdata), .i_wb_sel (wb_sel),
		.o_wb_stall (wb_stall), .o_wb_ack (wb_ack),
		.o_wb_data (wb_rdata), .o_wb_err (wb_err),
		.o_axi_awvalid (axi_awvalid), .i_axi_awready (axi_awready),
		.o_axi_awaddr (axi_awaddr), .o_axi_awprot (axi_awprot),
		.o_axi_wvalid (axi_wvalid), .i_axi_wready (axi_wready),
		.o_axi_wdata (axi_wdata), .o_axi_wstrb (axi_wstrb),
		.i_axi_bvalid (axi_bvalid), .o_axi_bready (axi_bready), .i_axi_bresp (axi_bresp),
		.o_axi_arvalid (axi_arvalid), .i_axi_arready (axi_arready),
		.o_axi_araddr (axi_araddr), .o_axi_arprot (axi_arprot),
		.i_axi_rvalid (axi_rvalid), .o_axi_rready (axi_rready),
		.i_axi_rdata (axi_rdata), .i_axi_rresp (axi_rresp)
	);

	axil_slave_model u_slave (
		.i_clk (clk), .i_reset (reset), .i_err_addr ({ERR_WORD, 2'b00}),
		.i_awvalid (axi_awvalid), .o_awready (axi_awready), .i_awaddr (axi_awaddr),
		.i_wvalid (axi_wvalid), .o_wready (axi_wready),
		.i_wdata (axi_wdata), .i_wstrb (axi_wstrb),
		.o_bvalid (axi_bvalid), .o_bresp (axi_bresp),
		.i_arvalid (axi_arvalid), .o_arready (axi_arready), .i_araddr (axi_araddr),
		.o_rvalid (axi_rvalid), .o_rdata (axi_rdata), .o_rresp (axi_rresp)
	);

	always #50 clk = ~clk;

	task automatic report_problem(input string what);
		errors++;
		$display("Error in %s at %0t: %s", test_name, $time, what);
	endtask

	task automatic report_mismatch(input string field, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		errors++;
		$display("[FAIL] %s %s: expected %h, actual %h", test_name, field, exp_v, act_v);
	endtask

	// Byte lanes with a strobe take the new value
	function automatic data_t apply_strobes(data_t old_word, data_t new_word, sel_t sel);
		data_t res;
		res = old_word;
		for (int b = 0; b < SEL_W; b++)
			if (sel[b])
				res[8*b +: 8] = new_word[8*b +: 8];
		return res;
	endfunction

	// Leaves stb high, so calls in a row form a pipelined burst
	task automatic issue_req(input logic we, input wb_addr_t addr, input data_t data,
		input sel_t sel);
		logic taken;
		wb_stb = 1'b1;
		wb_we = we;
		wb_addr = addr;
		wb_wdata = data;
		wb_sel = sel;
		taken = 1'b0;
		while (!taken)
		begin
			// Stall is settled by mid cycle
			@(negedge clk);
			taken = !wb_stall;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic finish_burst();
		wb_stb = 1'b0;
		@(posedge clk);
		#1;
		while (exp_q.size() != 0)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Scoreboard
	//////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		exp_t e;
		if (reset)
		begin
			exp_q.delete();
			cyc_prev = 1'b0;
			tb_pending = 1'b0;
			last_we = 1'b0;
		end
		else
		begin
			// Answers first, they belong to earlier requests
			if (wb_ack || wb_err)
			begin
				if (!cyc_prev)
					report_problem("ack or error returned for a dropped cycle");
				else if (exp_q.size() == 0)
					report_problem("ack or error with no request outstanding");
				else
				begin
					e = exp_q.pop_front();
					if (wb_err != e.err)
						report_mismatch("error flag", 32'(e.err), 32'(wb_err));
					else if (wb_ack && !e.we && (wb_rdata != e.data))
						report_mismatch("read data", e.data, wb_rdata);
					// Everything behind an error is swallowed by the drain
					if (wb_err)
						exp_q.delete();
				end
			end
			// Dropped cycle cancels all answers still due
			if (!wb_cyc)
				exp_q.delete();
			if (wb_stb && !wb_stall)
			begin
				e.we = wb_we;
				e.err = (wb_addr == ERR_WORD);
				e.data = model[wb_addr[5:0]];
				if (wb_we && !e.err)
					model[wb_addr[5:0]] = apply_strobes(model[wb_addr[5:0]], wb_wdata, wb_sel);
				exp_q.push_back(e);
				last_we = wb_we;
			end
			cyc_prev = wb_cyc;
			tb_pending = (exp_q.size() != 0);
		end
	end

	//////////////////////////////////////////////////////////////
	// Bus checks
	//////////////////////////////////////////////////////////////

	a_reset_quiet: assert property (@(posedge clk)
		reset |=> (wb_stall && !axi_awvalid && !axi_wvalid && !axi_arvalid))
		else report_problem("stall low or an AXI valid high right after reset");

	// Byte address is the word address times four
	a_write_issue: assert property (@(posedge clk) disable iff (reset)
		(wb_stb && !wb_stall && wb_we) |=> (axi_awvalid && axi_wvalid
		&& (axi_awaddr == (axi_addr_t'($past(wb_addr)) * 4))
		&& (axi_wdata == $past(wb_wdata)) && (axi_wstrb == $past(wb_sel))))
		else report_problem("write not issued on AW and W with its address, data and strobes");

	a_read_issue: assert property (@(posedge clk) disable iff (reset)
		(wb_stb && !wb_stall && !wb_we) |=> (axi_arvalid
		&& (axi_araddr == (axi_addr_t'($past(wb_addr)) * 4))))
		else report_problem("read not issued on AR with its byte address");

	a_aw_hold: assert property (@(posedge clk) disable iff (reset)
		(axi_awvalid && !axi_awready) |=> (axi_awvalid && $stable(axi_awaddr)))
		else report_problem("AW valid or address changed before ready");

	a_ar_hold: assert property (@(posedge clk) disable iff (reset)
		(axi_arvalid && !axi_arready) |=> (axi_arvalid && $stable(axi_araddr)))
		else report_problem("AR valid or address changed before ready");

	// Direction may only turn once every answer is back
	a_dir_stall: assert property (@(posedge clk) disable iff (reset)
		(wb_stb && tb_pending && (wb_we != last_we)) |-> wb_stall)
		else report_problem("direction change accepted with answers outstanding");

	a_err_block: assert property (@(posedge clk) disable iff (reset)
		wb_err |-> wb_stall)
		else report_problem("bridge not stalled while draining after an error");

	// Constant outputs of the bridge
	a_awprot: assert property (@(posedge clk) disable iff (reset)
		axi_awprot == EXP_PROT)
		else report_mismatch("AWPROT", 32'(EXP_PROT), 32'(axi_awprot));

	a_arprot: assert property (@(posedge clk) disable iff (reset)
		axi_arprot == EXP_PROT)
		else report_mismatch("ARPROT", 32'(EXP_PROT), 32'(axi_arprot));

	a_resp_ready: assert property (@(posedge clk) disable iff (reset)
		axi_bready && axi_rready)
		else report_problem("BREADY or RREADY low although responses are never held off");

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles with %0d errors", cycles, errors);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////

	initial
	begin
		int hold_cycles;
		int i;
		clk = 1'b0;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_addr = '0;
		wb_wdata = '0;
		wb_sel = '0;
		test_name = "reset_hold";
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		hold_cycles = 0;
		while (wb_stall)
		begin
			@(posedge clk);
			#1;
			hold_cycles++;
		end
		if (hold_cycles > RESET_HOLD + 1)
			report_mismatch("hold cycles at most", RESET_HOLD + 1, hold_cycles);

		wb_cyc = 1'b1;
		test_name = "single_write";
		issue_req(1'b1, wb_addr_t'(1), 32'h1234_5678, 4'hf);
		issue_req(1'b1, wb_addr_t'(1), 32'hcafe_f00d, 4'h5);
		finish_burst();

		test_name = "read_burst";
		for (i = 2; i < 10; i++)
			issue_req(1'b1, wb_addr_t'(i), 32'ha5a5_0000 + 32'(i * 273), 4'hf);
		finish_burst();
		issue_req(1'b0, wb_addr_t'(1), '0, 4'hf);
		for (i = 2; i < 10; i++)
			issue_req(1'b0, wb_addr_t'(i), '0, 4'hf);
		finish_burst();

		test_name = "dir_switch";
		issue_req(1'b1, wb_addr_t'(10), 32'h0000_aaaa, 4'hf);
		issue_req(1'b1, wb_addr_t'(11), 32'h0000_bbbb, 4'hf);
		issue_req(1'b1, wb_addr_t'(12), 32'h0000_cccc, 4'hf);
		// Held off until the three writes are acked
		issue_req(1'b0, wb_addr_t'(10), '0, 4'hf);
		issue_req(1'b0, wb_addr_t'(11), '0, 4'hf);
		issue_req(1'b1, wb_addr_t'(13), 32'h0000_dddd, 4'hf);
		finish_burst();

		test_name = "error_drain";
		issue_req(1'b1, wb_addr_t'(14), 32'h0bad_0014, 4'hf);
		issue_req(1'b1, ERR_WORD, 32'hdead_dead, 4'hf);
		issue_req(1'b1, wb_addr_t'(15), 32'h0bad_0015, 4'hf);
		finish_burst();
		issue_req(1'b0, wb_addr_t'(14), '0, 4'hf);
		finish_burst();

		test_name = "cycle_drop";
		issue_req(1'b1, wb_addr_t'(20), 32'h2020_2020, 4'hf);
		issue_req(1'b1, wb_addr_t'(21), 32'h2121_2121, 4'hf);
		issue_req(1'b1, wb_addr_t'(22), 32'h2222_2222, 4'hf);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		wb_cyc = 1'b1;
		issue_req(1'b0, wb_addr_t'(20), '0, 4'hf);
		issue_req(1'b0, wb_addr_t'(22), '0, 4'hf);
		finish_burst();

		wb_cyc = 1'b0;
		repeat (2) @(posedge clk);
		$display("Run finished after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
